//--- build.f
common/mxu_prec_pkg.sv
common/mxu_cmd_pkg.sv
common/mxu_wload_if.sv
mxu_array/smac.sv
mxu_array/mxu_mac.sv
mxu_array/mxu_array.sv
source/mxu_skew.sv
source/mxu_ctrl.sv
source/mxu_top.sv
test/mxu_props.sv
test/mxu_checker.sv
test/tb_mxu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mxu
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/tb_mxu.sv
`timescale 1ns/10ps
`default_nettype none

// testbench for mxu_top, seeded random vectors against a lane model
module tb_mxu
  import mxu_prec_pkg::*, mxu_cmd_pkg::*;
;

  localparam int rows   = 4;
  localparam int cols   = 4;
  localparam int n_cmds = 256;  // upper bound on commands issued
  localparam int limit  = n_cmds * (2 * (rows + cols) + 10);  // watchdog, cycles

  logic                        clk = 1'b0;
  logic                        arst_n = 1'b0;
  logic                        cmd_valid = 1'b0;
  cmd_op_e                     cmd_op = op_nop;
  logic [addr_w(rows)-1:0]     cmd_row = '0;
  logic [addr_w(cols)-1:0]     cmd_col = '0;
  logic [cols-1:0][word_w-1:0] cmd_data = '0;
  logic                        busy;
  logic                        out_valid;
  logic [rows-1:0][word_w-1:0] out_data;
  logic                        push_valid = 1'b0;
  logic [rows-1:0][word_w-1:0] push_data = '0;
  int                          err_count, match_count, pending;

  logic [word_w-1:0] w_m [rows][cols];  // weight model
  logic [1:0]        prec_m;            // precision model
  int                tb_err = 0;
  int                e0, m0;
  logic [cols-1:0][word_w-1:0] vs [4];  // vectors replayed in the reload test

  always #2 clk = ~clk;  // 4 ns period

  mxu_top #(.rows(rows), .cols(cols)) dut (
    .clk(clk), .arst_n(arst_n), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
    .cmd_row(cmd_row), .cmd_col(cmd_col), .cmd_data(cmd_data),
    .busy(busy), .out_valid(out_valid), .out_data(out_data)
  );

  mxu_checker #(.rows(rows), .cols(cols)) u_chk (
    .clk(clk), .push_valid(push_valid), .push_data(push_data),
    .out_valid(out_valid), .out_data(out_data),
    .err_count(err_count), .match_count(match_count), .pending(pending)
  );

  // per-lane dot product, each lane wraps at its own width
  function automatic logic [rows-1:0][word_w-1:0] model_rows(
    input logic [cols-1:0][word_w-1:0] x, input logic [1:0] p);
    int nl;
    int lw;
    logic [31:0] mask, acc, xa, wa;
    logic [rows-1:0][word_w-1:0] res;
    nl   = (p == 2'd1) ? 2 : (p == 2'd2) ? 4 : 1;
    lw   = 16 / nl;
    mask = (32'd1 << lw) - 1;
    res  = '0;
    for (int r = 0; r < rows; r++) begin
      for (int l = 0; l < nl; l++) begin
        acc = 0;
        for (int c = 0; c < cols; c++) begin
          xa  = (32'(x[c]) >> (l * lw)) & mask;
          wa  = (32'(w_m[r][c]) >> (l * lw)) & mask;
          acc = acc + xa * wa;
        end
        res[r] = res[r] | word_w'((acc & mask) << (l * lw));
      end
    end
    return res;
  endfunction

  // one command on the next edge, left asserted for back-to-back use
  task automatic drive_cmd(input cmd_op_e op, input int r, input int c,
                           input logic [cols-1:0][word_w-1:0] d,
                           input logic push, input logic [rows-1:0][word_w-1:0] e);
    @(posedge clk);
    cmd_valid  <= 1'b1;
    cmd_op     <= op;
    cmd_row    <= r[addr_w(rows)-1:0];
    cmd_col    <= c[addr_w(cols)-1:0];
    cmd_data   <= d;
    push_valid <= push;
    push_data  <= e;
  endtask

  task automatic go_idle();
    @(posedge clk);
    cmd_valid  <= 1'b0;
    cmd_op     <= op_nop;
    push_valid <= 1'b0;
  endtask

  task automatic load_weight(input int r, input int c, input logic [word_w-1:0] w);
    logic [cols-1:0][word_w-1:0] d;
    d    = '0;
    d[0] = w;  // weight rides in the low word
    w_m[r][c] = w;
    drive_cmd(op_load_w, r, c, d, 1'b0, '0);
  endtask

  task automatic stream_vec(input logic [cols-1:0][word_w-1:0] x);
    drive_cmd(op_stream, 0, 0, x, 1'b1, model_rows(x, prec_m));
  endtask

  // returns whether busy was seen high during the drain
  task automatic set_precision(input logic [1:0] p, output logic saw_busy);
    logic [cols-1:0][word_w-1:0] d;
    d         = '0;
    d[0][1:0] = p;  // mode code in the low bits
    prec_m    = p;
    saw_busy  = 1'b0;
    drive_cmd(op_set_prec, 0, 0, d, 1'b0, '0);
    go_idle();
    @(posedge clk);
    while (busy) begin
      saw_busy = 1'b1;
      @(posedge clk);
    end
  endtask

  task automatic wait_results();
    go_idle();
    repeat (3) @(posedge clk);
    while (pending != 0) @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  task automatic load_random();
    for (int r = 0; r < rows; r++)
      for (int c = 0; c < cols; c++)
        load_weight(r, c, word_w'($urandom));
  endtask

  function automatic logic [cols-1:0][word_w-1:0] rand_vec();
    logic [cols-1:0][word_w-1:0] v;
    for (int c = 0; c < cols; c++) v[c] = word_w'($urandom);
    return v;
  endfunction

  task automatic test_begin();
    e0 = err_count + tb_err;
    m0 = match_count;
  endtask

  task automatic test_end(input string name);
    $display("test %s: %0d rows matched, %0d errors", name, match_count - m0,
             err_count + tb_err - e0);
  endtask

  ////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////
  initial begin
    #(limit * 4);
    $display("watchdog expired before the tests finished");
    $display("Verification failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic sb;
    void'($urandom(32'h7f7f));
    prec_m = 2'd0;
    for (int r = 0; r < rows; r++)
      for (int c = 0; c < cols; c++)
        w_m[r][c] = '0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk);

    test_begin();  // identity weights, output equals input
    for (int r = 0; r < rows; r++)
      for (int c = 0; c < cols; c++)
        load_weight(r, c, (r == c) ? 16'd1 : 16'd0);
    for (int i = 0; i < 8; i++) stream_vec(rand_vec());
    wait_results();
    test_end("1 identity int16");

    test_begin();
    load_random();
    for (int i = 0; i < 20; i++) stream_vec(rand_vec());
    wait_results();
    test_end("2 random int16");

    test_begin();
    set_precision(2'd1, sb);
    if (sb) begin
      $display("busy rose for a precision change with nothing in flight");
      tb_err = tb_err + 1;
    end
    load_random();
    for (int i = 0; i < 20; i++) stream_vec(rand_vec());
    wait_results();
    test_end("3a random int8");

    test_begin();
    set_precision(2'd2, sb);
    if (sb) begin
      $display("busy rose for a precision change with nothing in flight");
      tb_err = tb_err + 1;
    end
    load_random();
    for (int i = 0; i < 20; i++) stream_vec(rand_vec());
    wait_results();
    test_end("3b random int4");

    test_begin();  // precision change with vectors in flight
    for (int i = 0; i < 6; i++) stream_vec(rand_vec());
    set_precision(2'd1, sb);
    if (!sb) begin
      $display("busy did not rise for a precision change with vectors in flight");
      tb_err = tb_err + 1;
    end
    for (int i = 0; i < 6; i++) stream_vec(rand_vec());
    wait_results();
    test_end("4 drain on precision change");

    test_begin();  // single weight reload
    for (int i = 0; i < 4; i++) vs[i] = rand_vec();
    for (int i = 0; i < 4; i++) stream_vec(vs[i]);
    wait_results();
    load_weight(2, 1, word_w'($urandom));
    for (int i = 0; i < 4; i++) stream_vec(vs[i]);
    wait_results();
    test_end("5 weight reload");

    $display("checks: %0d rows matched, %0d errors", match_count, err_count + tb_err);
    if (err_count + tb_err == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/mxu_checker.sv
`timescale 1ns/10ps
`default_nettype none

// scoreboard, expected rows in, DUT rows out
module mxu_checker
  import mxu_prec_pkg::*;
#(
  parameter int rows = 4,
  parameter int cols = 4
) (
  input  wire                         clk,
  input  wire                         push_valid,  // same edge as the stream strobe
  input  wire [rows-1:0][word_w-1:0]  push_data,
  input  wire                         out_valid,
  input  wire [rows-1:0][word_w-1:0]  out_data,
  output int                          err_count,
  output int                          match_count,
  output int                          pending
);

  // out_valid is seen here 2*(rows+cols) edges after the stream strobe
  localparam longint lat = 2 * (rows + cols);

  logic [rows-1:0][word_w-1:0] exp_q [$];
  longint                      t_q [$];
  longint                      cyc = 0;
  logic [rows-1:0][word_w-1:0] exp_v;
  longint                      t_v;

  initial begin
    err_count   = 0;
    match_count = 0;
    pending     = 0;
  end

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (push_valid) begin
      exp_q.push_back(push_data);
      t_q.push_back(cyc);
    end
    if (out_valid) begin
      if (exp_q.size() == 0) begin
        $display("out_valid went high with no result expected");
        err_count = err_count + 1;
      end else begin
        exp_v = exp_q.pop_front();
        t_v   = t_q.pop_front();
        if (cyc - t_v != lat) begin
          $display("Mismatch latency: got %h expected %h", cyc - t_v, lat);
          err_count = err_count + 1;
        end
        for (int r = 0; r < rows; r++) begin
          if (out_data[r] !== exp_v[r]) begin
            $display("Mismatch out_data[%0d]: got %h expected %h", r, out_data[r], exp_v[r]);
            err_count = err_count + 1;
          end else begin
            match_count = match_count + 1;
          end
        end
      end
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

//--- test/mxu_props.sv
`timescale 1ns/10ps
`default_nettype none

// controller assertions, bound into every mxu_ctrl
module mxu_props
  import mxu_cmd_pkg::*;
(
  input wire         clk,
  input wire         arst_n,
  input wire         busy,
  input ctrl_state_e state,
  input wire         wen,
  input wire         out_valid
);

  // drain ends only after the last in-flight result has left
  a_drain_done: assert property (@(posedge clk) disable iff (!arst_n)
    (state == st_run) && ($past(state) == st_drain) |-> !out_valid)
    else $error("drain ended with a result still in flight");

  // no weight write slips in during a drain
  a_no_wen_busy: assert property (@(posedge clk) disable iff (!arst_n)
    !(wen && busy)) else $error("weight strobe while busy");

  a_rst_valid: assert property (@(posedge clk)
    !arst_n |-> !out_valid) else $error("out_valid high during reset");

endmodule

bind mxu_ctrl mxu_props u_props (
  .clk       (clk),
  .arst_n    (arst_n),
  .busy      (busy),
  .state     (state),
  .wen       (wl.wen),
  .out_valid (out_valid)
);

`default_nettype wire

//--- source/mxu_top.sv
`timescale 1ns/10ps
`default_nettype none

// vector-by-matrix unit, weight stationary
module mxu_top
  import mxu_prec_pkg::*, mxu_cmd_pkg::*;
#(
  parameter int rows = 4,
  parameter int cols = 4
) (
  input  wire                          clk,
  input  wire                          arst_n,
  input  wire                          cmd_valid,
  input  var cmd_op_e                  cmd_op,
  input  wire [addr_w(rows)-1:0]       cmd_row,
  input  wire [addr_w(cols)-1:0]       cmd_col,
  input  wire [cols-1:0][word_w-1:0]   cmd_data,   // one word per column
  output logic                         busy,
  output logic                         out_valid,
  output logic [rows-1:0][word_w-1:0]  out_data    // one dot product per row
);

  prec_e                       prec;
  logic [cols-1:0][word_w-1:0] vec;      // registered input vector
  logic [cols-1:0][word_w-1:0] col_in;   // skewed columns into the grid
  logic [rows-1:0][word_w-1:0] row_out;  // skewed row results
  logic [rows-1:0][word_w-1:0] res_d;    // realigned row results

  mxu_wload_if #(.rows(rows), .cols(cols)) wl ();

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////
  mxu_ctrl #(.rows(rows), .cols(cols)) u_ctrl (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_row   (cmd_row),
    .cmd_col   (cmd_col),
    .cmd_data  (cmd_data),
    .wl        (wl.ctrl),
    .prec      (prec),
    .vec       (vec),
    .busy      (busy),
    .out_valid (out_valid)
  );

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////
  mxu_skew #(.lanes(cols), .word_w(word_w), .step(2), .rising(1'b1)) u_skew_in (
    .clk    (clk),
    .arst_n (arst_n),
    .din    (vec),
    .dout   (col_in)   // column c late by 2c
  );

  mxu_array #(.rows(rows), .cols(cols)) u_array (
    .clk     (clk),
    .arst_n  (arst_n),
    .wl      (wl.array),
    .prec    (prec),
    .col_in  (col_in),
    .row_out (row_out)
  );

  mxu_skew #(.lanes(rows), .word_w(word_w), .step(2), .rising(1'b0)) u_skew_out (
    .clk    (clk),
    .arst_n (arst_n),
    .din    (row_out),
    .dout   (res_d)    // row r late by 2(rows-1-r), rows line up again
  );

  always_ff @(posedge clk) begin
    out_data <= res_d;  // final output stage, aligned with out_valid
  end

endmodule

`default_nettype wire

//--- source/mxu_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

// command decode, precision register, drain fsm and output-valid tracking
module mxu_ctrl
  import mxu_prec_pkg::*, mxu_cmd_pkg::*;
#(
  parameter int rows = 4,
  parameter int cols = 4
) (
  input  wire                          clk,
  input  wire                          arst_n,
  input  wire                          cmd_valid,  // single-cycle strobe
  input  var cmd_op_e                  cmd_op,
  input  wire [addr_w(rows)-1:0]       cmd_row,
  input  wire [addr_w(cols)-1:0]       cmd_col,
  input  wire [cols-1:0][word_w-1:0]   cmd_data,
  mxu_wload_if.ctrl                    wl,
  output prec_e                        prec,       // level to every cell
  output logic [cols-1:0][word_w-1:0]  vec,        // registered vector to input skew
  output logic                         busy,
  output logic                         out_valid
);

  localparam int dly = 2 * (rows + cols);  // stream strobe to out_valid, in cycles

  ctrl_state_e state;
  prec_e       prec_pend;   // precision waiting for the drain to finish
  logic        accept;
  logic        go_stream;
  logic        in_flight;
  logic [dly-1:0] vld_q;    // strobe delay line, bit k set k cycles after the stream edge

  assign accept    = cmd_valid && !busy;  // strobes while busy are dropped
  assign go_stream = accept && (cmd_op == op_stream);
  assign in_flight = |vld_q;              // any vector still inside the pipeline
  assign busy      = (state == st_drain);
  assign out_valid = vld_q[dly-1];

  ////////////////////////////////////////////////////////////
  // valid delay line
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[dly-2:0], go_stream};  // shift in one bit per cycle
    end
  end

  // vector register, the first cycle of the stream path
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vec <= '0;
    end else if (go_stream) begin
      vec <= cmd_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // weight load
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wl.wen <= 1'b0;
    end else begin
      wl.wen <= accept && (cmd_op == op_load_w);  // pulse for one cycle
    end
  end

  always_ff @(posedge clk) begin
    if (accept && (cmd_op == op_load_w)) begin
      wl.wrow  <= cmd_row;
      wl.wcol  <= cmd_col;
      wl.wdata <= cmd_data[0];  // low word carries the weight
    end
  end

  ////////////////////////////////////////////////////////////
  // precision and drain fsm
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= st_run;
      prec      <= prec_int16;
      prec_pend <= prec_int16;
    end else begin
      case (state)
        st_run: begin
          if (accept && (cmd_op == op_set_prec)) begin
            if (in_flight) begin
              prec_pend <= prec_e'(cmd_data[0][1:0]);  // hold until pipeline empties
              state     <= st_drain;
            end else begin
              prec <= prec_e'(cmd_data[0][1:0]);       // idle, apply at once
            end
          end
        end
        st_drain: begin
          if (!in_flight) begin
            prec  <= prec_pend;
            state <= st_run;
          end
        end
        default: state <= st_run;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/mxu_skew.sv
`timescale 1ns/10ps
`default_nettype none

// staircase delay, lane i delayed by step*i (rising) or step*(lanes-1-i)
module mxu_skew #(
  parameter int lanes  = 4,
  parameter int word_w = 16,
  parameter int step   = 2,
  parameter bit rising = 1'b1
) (
  input  wire                           clk,
  input  wire                           arst_n,
  input  wire  [lanes-1:0][word_w-1:0]  din,
  output logic [lanes-1:0][word_w-1:0]  dout
);

  for (genvar i = 0; i < lanes; i++) begin : g_lane
    localparam int d = rising ? step * i : step * (lanes - 1 - i);  // depth of this lane

    if (d == 0) begin : g_pass
      assign dout[i] = din[i];  // zero-delay lane
    end else begin : g_dly
      logic [word_w-1:0] sr [d];  // shift stages, sr[d-1] is the oldest

      always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
          for (int k = 0; k < d; k++) begin
            sr[k] <= '0;
          end
        end else begin
          sr[0] <= din[i];
          for (int k = 1; k < d; k++) begin
            sr[k] <= sr[k-1];  // advance one stage per cycle
          end
        end
      end

      assign dout[i] = sr[d-1];
    end
  end

endmodule

`default_nettype wire

//--- mxu_array/mxu_array.sv
`timescale 1ns/10ps
`default_nettype none

// rows x cols grid of mac cells
// data moves down the columns, partial sums move left to right
module mxu_array
  import mxu_prec_pkg::*;
#(
  parameter int rows = 4,
  parameter int cols = 4
) (
  input  wire                          clk,
  input  wire                          arst_n,
  mxu_wload_if.array                   wl,
  input  var prec_e                    prec,
  input  wire [cols-1:0][word_w-1:0]   col_in,   // skewed vector, one word per column
  output logic [rows-1:0][word_w-1:0]  row_out   // last-column result of each row
);

  localparam int row_w = $bits(wl.wrow);
  localparam int col_w = $bits(wl.wcol);

  logic [word_w-1:0] data_v [rows+1][cols];  // data_v[r] feeds row r
  logic [word_w-1:0] psum   [rows][cols+1];  // psum[r][c] feeds cell (r,c)

  for (genvar c = 0; c < cols; c++) begin : g_top
    assign data_v[0][c] = col_in[c];  // row 0 straight from the skew
  end

  for (genvar r = 0; r < rows; r++) begin : g_row
    assign psum[r][0] = '0;           // chain starts at zero
    assign row_out[r] = psum[r][cols];

    for (genvar c = 0; c < cols; c++) begin : g_col
      logic w_en;

      // weight strobe for this cell only
      assign w_en = wl.wen && (wl.wrow == row_w'(r)) && (wl.wcol == col_w'(c));

      mxu_mac u_mac (
        .clk                 (clk),
        .arst_n              (arst_n),
        .w_en                (w_en),
        .w_data              (wl.wdata),
        .prec                (prec),
        .data_input          (data_v[r][c]),
        .res_mac_p           (psum[r][c]),
        .res_mac_n           (psum[r][c+1]),
        .data_input_next_row (data_v[r+1][c])
      );
    end
  end

endmodule

`default_nettype wire

//--- mxu_array/mxu_mac.sv
`timescale 1ns/10ps
`default_nettype none

// one grid cell, stationary weight plus multiply-add
module mxu_mac
  import mxu_prec_pkg::*;
(
  input  wire                 clk,
  input  wire                 arst_n,
  input  wire                 w_en,                 // load strobe for this cell
  input  wire  [word_w-1:0]   w_data,
  input  var prec_e           prec,
  input  wire  [word_w-1:0]   data_input,           // from the row above
  input  wire  [word_w-1:0]   res_mac_p,            // partial sum from the left
  output logic [word_w-1:0]   res_mac_n,            // partial sum to the right
  output logic [word_w-1:0]   data_input_next_row   // to the row below
);

  logic [word_w-1:0] weight;
  logic [word_w-1:0] d1_q;  // first data delay stage
  logic [word_w-1:0] d2_q;  // second stage, lines up with smac output

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      weight <= '0;  // grid starts all zero
    end else if (w_en) begin
      weight <= w_data;
    end
  end

  smac u_smac (
    .clk    (clk),
    .arst_n (arst_n),
    .prec   (prec),
    .a      (data_input),
    .b      (weight),
    .c      (res_mac_p),
    .p      (res_mac_n)
  );

  // two stages, matches the smac latency
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      d1_q <= '0;
      d2_q <= '0;
    end else begin
      d1_q <= data_input;
      d2_q <= d1_q;
    end
  end

  assign data_input_next_row = d2_q;

endmodule

`default_nettype wire

//--- mxu_array/smac.sv
`timescale 1ns/10ps
`default_nettype none

// lane-split multiply-add, p = a*b + c per lane, two pipeline stages
module smac
  import mxu_prec_pkg::*;
(
  input  wire                clk,
  input  wire                arst_n,
  input  var prec_e          prec,
  input  wire  [word_w-1:0]  a,     // data word
  input  wire  [word_w-1:0]  b,     // weight word
  input  wire  [word_w-1:0]  c,     // incoming partial sum
  output logic [word_w-1:0]  p
);

  logic [prec_n-1:0][word_w-1:0] prod;  // lane products for every mode
  logic [prec_n-1:0][word_w-1:0] sum;   // lane sums for every mode
  logic [word_w-1:0] prod_q;            // stage 1 product, chosen mode
  logic [word_w-1:0] c_q;               // stage 1 partial sum
  prec_e             prec_q;            // mode travels with its data

  // products and sums wrap at the lane width, so sign does not matter
  for (genvar k = 0; k < prec_n; k++) begin : g_prec
    localparam int nl = lanes_of(prec_e'(k));
    localparam int lw = lane_w_of(prec_e'(k));

    for (genvar i = 0; i < nl; i++) begin : g_lane
      assign prod[k][i*lw +: lw] = a[i*lw +: lw] * b[i*lw +: lw];     // no carry out
      assign sum[k][i*lw +: lw]  = prod_q[i*lw +: lw] + c_q[i*lw +: lw];
    end
  end

  ////////////////////////////////////////////////////////////
  // stage 1 and stage 2
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prod_q <= '0;
      c_q    <= '0;
      prec_q <= prec_int16;
      p      <= '0;
    end else begin
      case (prec)
        prec_int8: prod_q <= prod[1];
        prec_int4: prod_q <= prod[2];
        default:   prod_q <= prod[0];  // int16, also unknown codes
      endcase
      c_q    <= c;
      prec_q <= prec;
      case (prec_q)
        prec_int8: p <= sum[1];
        prec_int4: p <= sum[2];
        default:   p <= sum[0];
      endcase
    end
  end

endmodule

`default_nettype wire

//--- common/mxu_wload_if.sv
`timescale 1ns/10ps
`default_nettype none

// weight-load bus from the controller into the cell grid
interface mxu_wload_if
  import mxu_prec_pkg::*, mxu_cmd_pkg::*;
#(
  parameter int rows = 4,
  parameter int cols = 4
) ();

  localparam int row_w = addr_w(rows);
  localparam int col_w = addr_w(cols);

  logic              wen;    // one-cycle write strobe
  logic [row_w-1:0]  wrow;   // target row
  logic [col_w-1:0]  wcol;   // target column
  logic [word_w-1:0] wdata;  // weight value

  modport ctrl  (output wen, wrow, wcol, wdata);
  modport array (input  wen, wrow, wcol, wdata);

endinterface

`default_nettype wire

//--- common/mxu_cmd_pkg.sv
`default_nettype none

// command set and controller states
package mxu_cmd_pkg;

  typedef enum logic [1:0] {
    op_nop      = 2'd0,  // no operation
    op_load_w   = 2'd1,  // write one cell weight
    op_set_prec = 2'd2,  // change lane precision
    op_stream   = 2'd3   // push one input vector
  } cmd_op_e;

  typedef enum logic {
    st_run   = 1'b0,  // accepting commands
    st_drain = 1'b1   // waiting for in-flight vectors before a precision change
  } ctrl_state_e;

  // address width for n rows or columns, never below one bit
  function automatic int addr_w(int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

`default_nettype wire

//--- common/mxu_prec_pkg.sv
`default_nettype none

// precision modes and lane geometry shared by the datapath
package mxu_prec_pkg;

  localparam int word_w = 16;  // bits per data word
  localparam int prec_n = 3;   // number of supported precision modes

  // encoding is log2 of the lane count
  typedef enum logic [1:0] {
    prec_int16 = 2'd0,  // one 16-bit lane
    prec_int8  = 2'd1,  // two 8-bit lanes
    prec_int4  = 2'd2   // four 4-bit lanes
  } prec_e;

  // lanes per word, unknown codes fall back to a single lane
  function automatic int lanes_of(prec_e p);
    case (p)
      prec_int8: return 2;
      prec_int4: return 4;
      default:   return 1;
    endcase
  endfunction

  // lane width in bits, word_w split evenly over the lanes
  function automatic int lane_w_of(prec_e p);
    return word_w / lanes_of(p);
  endfunction

endpackage

`default_nettype wire
